//--- div_pkg.sv
/*
  shared widths, typedefs, function codes and loop count
  for the iterative divider, plus the execute state enum
*/
`default_nettype none

package div_pkg;

  // --------------------------------------------------
  // widths and loop length
  // --------------------------------------------------

  // operand, quotient and remainder width
  localparam int WORD_W = 32;

  // one quotient bit per step
  localparam int ITERATIONS = 32;

  // --------------------------------------------------
  // function codes on req_fn
  // --------------------------------------------------
  localparam logic FN_UNSIGNED = 1'b0;
  localparam logic FN_SIGNED   = 1'b1;

  // --------------------------------------------------
  // data types
  // --------------------------------------------------

  // operand, quotient or remainder
  typedef logic [WORD_W-1:0] word_t;

  // response word, remainder in the upper half
  typedef logic [2*WORD_W-1:0] result_t;

  // partial remainder with one guard bit for the trial sign
  typedef logic [2*WORD_W:0] ext_t;

  // iteration counter, 0 .. ITERATIONS-1
  typedef logic [$clog2(ITERATIONS)-1:0] count_t;

  // execute stage control
  typedef enum logic [1:0] {
    EXEC_IDLE,
    EXEC_CALC,
    EXEC_DONE
  } exec_state_t;

endpackage

`default_nettype wire

//--- div_decode.sv
/*
  request stage: accepts a division, forms the operand magnitudes
  and the sign flags, and holds them in a one-entry slot
*/
`timescale 1ns/1ps
`default_nettype none

module div_decode (
  input  logic           clk,
  input  logic           reset,
  input  logic           req_fn,
  input  div_pkg::word_t req_a,
  input  div_pkg::word_t req_b,
  input  logic           req_val,
  output logic           req_rdy,
  output div_pkg::word_t dec_mag_a,
  output div_pkg::word_t dec_mag_b,
  output logic           dec_quot_neg,
  output logic           dec_rem_neg,
  output logic           dec_val,
  input  logic           dec_rdy
);
  import div_pkg::*;

  logic  is_signed;
  logic  neg_a;
  logic  neg_b;
  word_t mag_a;
  word_t mag_b;
  logic  slot_val;
  logic  take;

  // --------------------------------------------------
  // operand decode
  // --------------------------------------------------
  always_comb begin
    case (req_fn)
      FN_SIGNED:   is_signed = 1'b1;
      FN_UNSIGNED: is_signed = 1'b0;
      default:     is_signed = 1'b0;
    endcase
  end

  // sign bits only count in signed mode
  assign neg_a = is_signed & req_a[WORD_W-1];
  assign neg_b = is_signed & req_b[WORD_W-1];

  // two's complement magnitude of a negative operand
  assign mag_a = neg_a ? (~req_a + 1'b1) : req_a;
  assign mag_b = neg_b ? (~req_b + 1'b1) : req_b;

  // --------------------------------------------------
  // one-entry slot
  // --------------------------------------------------

  // free when empty or when execute takes the entry this cycle
  assign req_rdy = !slot_val || dec_rdy;
  assign take    = req_val && req_rdy;
  assign dec_val = slot_val;

  always_ff @(posedge clk) begin
    if (reset) begin
      slot_val <= 1'b0;
    end else if (take) begin
      slot_val <= 1'b1;
    end else if (dec_rdy) begin
      // entry handed over with nothing new behind it
      slot_val <= 1'b0;
    end
  end

  // payload, loaded only on a new request
  always_ff @(posedge clk) begin
    if (take) begin
      dec_mag_a    <= mag_a;
      dec_mag_b    <= mag_b;
      // quotient is negative when the operand signs differ
      dec_quot_neg <= neg_a ^ neg_b;
      // remainder follows the dividend
      dec_rem_neg  <= neg_a;
    end
  end

endmodule

`default_nettype wire

//--- div_execute.sv
/*
  execute stage: restoring shift-and-subtract loop on the magnitudes,
  one quotient bit per clock, with its FSM and iteration counter
*/
`timescale 1ns/1ps
`default_nettype none

module div_execute (
  input  logic           clk,
  input  logic           reset,
  input  div_pkg::word_t dec_mag_a,
  input  div_pkg::word_t dec_mag_b,
  input  logic           dec_quot_neg,
  input  logic           dec_rem_neg,
  input  logic           dec_val,
  output logic           dec_rdy,
  output div_pkg::word_t exe_quot,
  output div_pkg::word_t exe_rem,
  output logic           exe_quot_neg,
  output logic           exe_rem_neg,
  output logic           exe_val,
  input  logic           exe_rdy
);
  import div_pkg::*;

  exec_state_t state;
  count_t      count;
  logic        last_step;
  logic        accept;
  logic        step;
  ext_t        part_rem;
  ext_t        div_shift;
  ext_t        rem_shift;
  ext_t        trial;

  // --------------------------------------------------
  // handshake
  // --------------------------------------------------

  // takes a new operation only when idle
  assign dec_rdy = (state == EXEC_IDLE);
  assign accept  = dec_val && dec_rdy;
  assign exe_val = (state == EXEC_DONE);

  // a loop step on every calc cycle except the closing one
  assign step = (state == EXEC_CALC) && !last_step;

  // --------------------------------------------------
  // control FSM
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= EXEC_IDLE;
      count     <= '0;
      last_step <= 1'b0;
    end else begin
      case (state)
        EXEC_IDLE: begin
          if (accept) begin
            state     <= EXEC_CALC;
            count     <= '0;
            last_step <= 1'b0;
          end
        end
        EXEC_CALC: begin
          if (last_step) begin
            // all quotient bits are in, one closing cycle
            state <= EXEC_DONE;
          end else begin
            count     <= count + 1'b1;
            last_step <= (count == count_t'(ITERATIONS - 1));
          end
        end
        EXEC_DONE: begin
          // hold the result until the result stage takes it
          if (exe_rdy) begin
            state <= EXEC_IDLE;
          end
        end
        default: begin
          state <= EXEC_IDLE;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------

  // shift first, then try to take the divisor off the top half
  assign rem_shift = part_rem << 1;
  assign trial     = rem_shift - div_shift;

  always_ff @(posedge clk) begin
    if (accept) begin
      // dividend in the low half, divisor lined up with the high half
      part_rem     <= ext_t'(dec_mag_a);
      div_shift    <= {1'b0, dec_mag_b, {WORD_W{1'b0}}};
      // sign flags just ride along to the result stage
      exe_quot_neg <= dec_quot_neg;
      exe_rem_neg  <= dec_rem_neg;
    end else if (step) begin
      if (trial[2*WORD_W]) begin
        // negative trial, restore the shifted value, quotient bit 0
        part_rem <= rem_shift;
      end else begin
        // divisor fits, quotient bit 1 into the freed low bit
        part_rem <= {trial[2*WORD_W:1], 1'b1};
      end
    end
  end

  // quotient builds up from the bottom, remainder sits above it
  assign exe_quot = part_rem[WORD_W-1:0];
  assign exe_rem  = part_rem[2*WORD_W-1:WORD_W];

endmodule

`default_nettype wire

//--- div_result.sv
/*
  result stage: sign correction of quotient and remainder,
  and the response register with its val/rdy handshake
*/
`timescale 1ns/1ps
`default_nettype none

module div_result (
  input  logic             clk,
  input  logic             reset,
  input  div_pkg::word_t   exe_quot,
  input  div_pkg::word_t   exe_rem,
  input  logic             exe_quot_neg,
  input  logic             exe_rem_neg,
  input  logic             exe_val,
  output logic             exe_rdy,
  output div_pkg::result_t resp_result,
  output logic             resp_val,
  input  logic             resp_rdy
);
  import div_pkg::*;

  word_t quot_fix;
  word_t rem_fix;
  logic  resp_full;
  logic  load;

  // --------------------------------------------------
  // sign correction
  // --------------------------------------------------

  // magnitudes come in, negate where the flags say so
  assign quot_fix = exe_quot_neg ? (~exe_quot + 1'b1) : exe_quot;
  assign rem_fix  = exe_rem_neg  ? (~exe_rem + 1'b1)  : exe_rem;

  // --------------------------------------------------
  // response register
  // --------------------------------------------------

  // free when empty or drained this cycle
  assign exe_rdy  = !resp_full || resp_rdy;
  assign load     = exe_val && exe_rdy;
  assign resp_val = resp_full;

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_full <= 1'b0;
    end else if (load) begin
      resp_full <= 1'b1;
    end else if (resp_rdy) begin
      resp_full <= 1'b0;
    end
  end

  // remainder over quotient
  always_ff @(posedge clk) begin
    if (load) begin
      resp_result <= {rem_fix, quot_fix};
    end
  end

endmodule

`default_nettype wire

//--- div_top.sv
/*
  divider top level: decode, execute and result stages in a row
*/
`timescale 1ns/1ps
`default_nettype none

module div_top (
  input  logic             clk,
  input  logic             reset,
  input  logic             req_fn,
  input  div_pkg::word_t   req_a,
  input  div_pkg::word_t   req_b,
  input  logic             req_val,
  output logic             req_rdy,
  output div_pkg::result_t resp_result,
  output logic             resp_val,
  input  logic             resp_rdy
);
  import div_pkg::*;

  // --------------------------------------------------
  // decode to execute
  // --------------------------------------------------
  word_t dec_mag_a;
  word_t dec_mag_b;
  logic  dec_quot_neg;
  logic  dec_rem_neg;
  logic  dec_val;
  logic  dec_rdy;

  // --------------------------------------------------
  // execute to result
  // --------------------------------------------------
  word_t exe_quot;
  word_t exe_rem;
  logic  exe_quot_neg;
  logic  exe_rem_neg;
  logic  exe_val;
  logic  exe_rdy;

  div_decode div_decode_inst (
    .clk          (clk),
    .reset        (reset),
    .req_fn       (req_fn),
    .req_a        (req_a),
    .req_b        (req_b),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .dec_mag_a    (dec_mag_a),
    .dec_mag_b    (dec_mag_b),
    .dec_quot_neg (dec_quot_neg),
    .dec_rem_neg  (dec_rem_neg),
    .dec_val      (dec_val),
    .dec_rdy      (dec_rdy)
  );

  div_execute div_execute_inst (
    .clk          (clk),
    .reset        (reset),
    .dec_mag_a    (dec_mag_a),
    .dec_mag_b    (dec_mag_b),
    .dec_quot_neg (dec_quot_neg),
    .dec_rem_neg  (dec_rem_neg),
    .dec_val      (dec_val),
    .dec_rdy      (dec_rdy),
    .exe_quot     (exe_quot),
    .exe_rem      (exe_rem),
    .exe_quot_neg (exe_quot_neg),
    .exe_rem_neg  (exe_rem_neg),
    .exe_val      (exe_val),
    .exe_rdy      (exe_rdy)
  );

  div_result div_result_inst (
    .clk          (clk),
    .reset        (reset),
    .exe_quot     (exe_quot),
    .exe_rem      (exe_rem),
    .exe_quot_neg (exe_quot_neg),
    .exe_rem_neg  (exe_rem_neg),
    .exe_val      (exe_val),
    .exe_rdy      (exe_rdy),
    .resp_result  (resp_result),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy)
  );

endmodule

`default_nettype wire

//--- div_checker.sv
/*
  assertions on the response handshake and the reset state of div_top
*/
`timescale 1ns/1ps
`default_nettype none

module div_checker (
  input logic             clk,
  input logic             reset,
  input logic             req_rdy,
  input logic             resp_val,
  input logic             resp_rdy,
  input div_pkg::result_t resp_result
);

  // first cycle out of reset, empty pipeline
  reset_state: assert property (@(posedge clk) $past(reset) && !reset |-> !resp_val && req_rdy)
    else $error("pipeline not empty after reset");

  // stalled response keeps its valid
  stall_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val)
    else $error("response valid dropped while stalled");

  // new data only into an empty or draining register
  held_result: assert property (@(posedge clk) disable iff (reset)
    !$stable(resp_result) |-> $past(!resp_val || resp_rdy))
    else $error("response data changed while held");

endmodule

bind div_top div_checker div_checker_inst (
  .clk         (clk),
  .reset       (reset),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result)
);

`default_nettype wire

//--- div_tb.sv
/*
  testbench for div_top: directed and random stimulus table, reference
  model, and a response consumer with random stalls
*/
`timescale 1ns/1ps
`default_nettype none

module div_tb;
  import div_pkg::*;

  localparam int RANDOM_N     = 40;
  localparam int REQ_TIMEOUT  = 400;
  localparam int RESP_TIMEOUT = 400;
  localparam int IDLE_CYCLES  = 5;
  localparam int DRAIN_CYCLES = 40;

  logic    clk;
  logic    reset;
  logic    req_fn;
  word_t   req_a;
  word_t   req_b;
  logic    req_val;
  logic    req_rdy;
  result_t resp_result;
  logic    resp_val;
  logic    resp_rdy;

  // stimulus table, one row per division, expected is remainder over quotient
  logic    tab_fn[$];
  word_t   tab_a[$];
  word_t   tab_b[$];
  result_t tab_exp[$];
  int      directed_n;

  // expected responses in request order
  result_t expected_q[$];
  int      max_depth;
  integer  seed;

  div_top div_top_inst (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------
  // reporting
  // --------------------------------------------------
  task automatic stop_run();
    $display("Errors found");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    stop_run();
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------

  // magnitude division, then sign correction
  function automatic result_t divide_model(input logic fn, input word_t a, input word_t b);
    logic  neg_a;
    logic  neg_b;
    word_t mag_a;
    word_t mag_b;
    word_t quot;
    word_t rem;
    neg_a = (fn == FN_SIGNED) && a[WORD_W-1];
    neg_b = (fn == FN_SIGNED) && b[WORD_W-1];
    mag_a = neg_a ? -a : a;
    mag_b = neg_b ? -b : b;
    if (mag_b == '0) begin
      // zero divisor, all quotient bits set and dividend left over
      quot = '1;
      rem  = mag_a;
    end else begin
      quot = mag_a / mag_b;
      rem  = mag_a % mag_b;
    end
    if (neg_a != neg_b) quot = -quot;
    // remainder takes the dividend's sign
    if (neg_a) rem = -rem;
    return {rem, quot};
  endfunction

  // --------------------------------------------------
  // stimulus table
  // --------------------------------------------------
  task automatic add_entry(input logic fn, input word_t a, input word_t b, input result_t exp);
    tab_fn.push_back(fn);
    tab_a.push_back(a);
    tab_b.push_back(b);
    tab_exp.push_back(exp);
  endtask

  task automatic build_table();
    word_t r;
    word_t a;
    word_t b;
    // unsigned, small dividend, divisor of one
    add_entry(FN_UNSIGNED, 32'd100,        32'd7,          {32'd2,        32'd14});
    add_entry(FN_UNSIGNED, 32'd5,          32'd9,          {32'd5,        32'd0});
    add_entry(FN_UNSIGNED, 32'hDEADBEEF,   32'd1,          {32'd0,        32'hDEADBEEF});
    add_entry(FN_UNSIGNED, 32'hFFFFFFFF,   32'h10,         {32'hF,        32'h0FFFFFFF});
    add_entry(FN_UNSIGNED, 32'h80000000,   32'd3,          {32'd2,        32'h2AAAAAAA});
    add_entry(FN_UNSIGNED, 32'h80000000,   32'hFFFFFFFF,   {32'h80000000, 32'd0});
    // signed, all four sign pairs of 100 and 7
    add_entry(FN_SIGNED,   32'd100,        32'd7,          {32'd2,        32'd14});
    add_entry(FN_SIGNED,   32'hFFFFFF9C,   32'd7,          {32'hFFFFFFFE, 32'hFFFFFFF2});
    add_entry(FN_SIGNED,   32'd100,        32'hFFFFFFF9,   {32'd2,        32'hFFFFFFF2});
    add_entry(FN_SIGNED,   32'hFFFFFF9C,   32'hFFFFFFF9,   {32'hFFFFFFFE, 32'd14});
    add_entry(FN_SIGNED,   32'd7,          32'd100,        {32'd7,        32'd0});
    add_entry(FN_SIGNED,   32'hFFFFFFF9,   32'd100,        {32'hFFFFFFF9, 32'd0});
    // most negative dividend over 1 and -1
    add_entry(FN_SIGNED,   32'h80000000,   32'd1,          {32'd0,        32'h80000000});
    add_entry(FN_SIGNED,   32'h80000000,   32'hFFFFFFFF,   {32'd0,        32'h80000000});
    // divide by zero in both modes
    add_entry(FN_UNSIGNED, 32'd1234,       32'd0,          {32'h4D2,      32'hFFFFFFFF});
    add_entry(FN_SIGNED,   32'd1234,       32'd0,          {32'h4D2,      32'hFFFFFFFF});
    add_entry(FN_SIGNED,   32'hFFFFFB2E,   32'd0,          {32'hFFFFFB2E, 32'd1});
    add_entry(FN_UNSIGNED, 32'd0,          32'd0,          {32'd0,        32'hFFFFFFFF});
    directed_n = tab_fn.size();
    for (int i = 0; i < directed_n; i++) begin
      check_value("model against table row", divide_model(tab_fn[i], tab_a[i], tab_b[i]),
                  tab_exp[i]);
    end
    for (int i = 0; i < RANDOM_N; i++) begin
      r = $random(seed);
      a = $random(seed);
      b = $random(seed);
      // now and then a short divisor for a wide quotient
      if (r[2:1] == 2'b00) b = b >> 20;
      add_entry(r[0], a, b, divide_model(r[0], a, b));
    end
  endtask

  // --------------------------------------------------
  // request driver and response consumer
  // --------------------------------------------------
  task automatic send_all();
    int waited;
    for (int i = 0; i < tab_fn.size(); i++) begin
      req_fn  = tab_fn[i];
      req_a   = tab_a[i];
      req_b   = tab_b[i];
      req_val = 1'b1;
      waited  = 0;
      // req_rdy comes from stage state only, settled at the falling edge
      while (!req_rdy) begin
        @(negedge clk);
        waited++;
        if (waited > REQ_TIMEOUT) report_failure("timeout: req_rdy stayed low too long");
      end
      expected_q.push_back(tab_exp[i]);
      if (expected_q.size() > max_depth) max_depth = expected_q.size();
      @(negedge clk);
    end
    req_val = 1'b0;
  endtask

  task automatic collect_responses(input int total);
    int      got;
    int      waited;
    int      stall_left;
    word_t   r;
    result_t exp;
    got        = 0;
    waited     = 0;
    stall_left = 0;
    while (got < total) begin
      if (stall_left > 0) begin
        resp_rdy = 1'b0;
        stall_left--;
      end else begin
        r        = $random(seed);
        resp_rdy = (r[2:0] != 3'd0);
        // occasional long stall to back up the whole pipeline
        if (r[2:0] == 3'd0) stall_left = int'(r[12:8]) * 3;
      end
      if (resp_val && resp_rdy) begin
        if (expected_q.size() == 0) report_failure("a response came with no request pending");
        exp = expected_q.pop_front();
        check_value("response", resp_result, exp);
        got++;
        waited = 0;
      end else begin
        waited++;
        if (waited > RESP_TIMEOUT) report_failure("timeout: the next response never came");
      end
      @(negedge clk);
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    int total;
    seed      = 73;
    reset     = 1'b1;
    req_fn    = FN_UNSIGNED;
    req_a     = '0;
    req_b     = '0;
    req_val   = 1'b0;
    resp_rdy  = 1'b0;
    max_depth = 0;
    build_table();
    total = tab_fn.size();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_value("req_rdy after reset", 64'(req_rdy), 64'd1);
    // idle, nothing may come out
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      check_value("resp_val while idle", 64'(resp_val), 64'd0);
      @(negedge clk);
    end
    fork
      send_all();
      collect_responses(total);
    join
    check_value("divisions in flight", 64'(max_depth >= 2), 64'd1);
    // pipeline drained, no extra response may follow
    resp_rdy = 1'b1;
    for (int i = 0; i < DRAIN_CYCLES; i++) begin
      check_value("resp_val after the last response", 64'(resp_val), 64'd0);
      @(negedge clk);
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
div_pkg.sv
div_decode.sv
div_execute.sv
div_result.sv
div_top.sv
div_checker.sv
div_tb.sv

//--- Makefile
# Verilator build and run of the divider testbench

VERILATOR ?= verilator
TOP       ?= div_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= No errors

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuild only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass message shows up in the output
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
